/* Bender.yml */
package:
  name: mips_alu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/alu_pkg.sv
      - verilog/alu_ctrl_if.sv
      - verilog/instr_decode.sv
      - verilog/alu_execute.sv
      - verilog/hilo_result.sv
      - verilog/mips_alu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_mips_alu.sv

/* build.f */
+incdir+include
verilog/alu_pkg.sv
verilog/alu_ctrl_if.sv
verilog/instr_decode.sv
verilog/alu_execute.sv
verilog/hilo_result.sv
verilog/mips_alu_top.sv
verif/tb_mips_alu.sv

/* include/alu_macros.svh */
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

`define ALU_XLEN 32

// major opcodes, instr[31:26]
`define OP_SPECIAL 6'd0
`define OP_REGIMM  6'd1
`define OP_BEQ     6'd4
`define OP_BNE     6'd5
`define OP_BLEZ    6'd6
`define OP_BGTZ    6'd7
`define OP_ADDI    6'd8
`define OP_ADDIU   6'd9
`define OP_SLTI    6'd10
`define OP_SLTIU   6'd11
`define OP_ANDI    6'd12
`define OP_ORI     6'd13
`define OP_XORI    6'd14
`define OP_LUI     6'd15
`define OP_LB      6'd32
`define OP_LH      6'd33
`define OP_LWL     6'd34
`define OP_LW      6'd35
`define OP_LBU     6'd36
`define OP_LHU     6'd37
`define OP_LWR     6'd38
`define OP_SB      6'd40
`define OP_SH      6'd41
`define OP_SWL     6'd42
`define OP_SW      6'd43

// REGIMM branch selects, held in the rt field
`define RT_BLTZ    5'd0
`define RT_BGEZ    5'd1
`define RT_BLTZAL  5'd16
`define RT_BGEZAL  5'd17

// SPECIAL funct codes, instr[5:0]
`define FN_SLL     6'd0
`define FN_SRL     6'd2
`define FN_SRA     6'd3
`define FN_SLLV    6'd4
`define FN_SRLV    6'd6
`define FN_SRAV    6'd7
`define FN_MFHI    6'd16
`define FN_MTHI    6'd17
`define FN_MFLO    6'd18
`define FN_MTLO    6'd19
`define FN_MULT    6'd24
`define FN_MULTU   6'd25
`define FN_DIV     6'd26
`define FN_DIVU    6'd27
`define FN_ADD     6'd32
`define FN_ADDU    6'd33
`define FN_SUB     6'd34
`define FN_SUBU    6'd35
`define FN_AND     6'd36
`define FN_OR      6'd37
`define FN_XOR     6'd38
`define FN_NOR     6'd39
`define FN_SLT     6'd42
`define FN_SLTU    6'd43

`endif

/* verif/tb_mips_alu.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module tb_mips_alu
    import alu_pkg::*;
();
    localparam int N_RAND = 8;
    localparam int N_ILL = 16;
    // reset, then each test plus its flush cycle
    localparam int RUN_CYCLES = 6 + 3 + (16 * N_RAND + 9) + (8 * N_RAND + 47) + 33 + 28
                                + (N_ILL + 1);
    localparam int CYCLE_LIMIT = RUN_CYCLES + 50;

    typedef struct packed {
        word_t result;
        word_t mem_addr;
        word_t hi;     // next HI if written
        word_t lo;
        logic  b_flag;
        logic  link;
        logic  illegal;
    } exp_t;

    logic   clk, arst_n, instr_valid;
    word_t  instr, op1, op2;
    word_t  result, hi, lo, mem_addr;
    logic   b_flag, link, illegal;
    word_t  m_hi, m_lo; // model HI/LO
    exp_t   e_now;
    logic   checking;
    int     errors, checks, test_errs, tests_run, cycle_cnt;
    integer seed = 99;

    mips_alu_top u_dut (
        .clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .instr(instr),
        .op1(op1), .op2(op2), .result(result), .hi(hi), .lo(lo),
        .mem_addr(mem_addr), .b_flag(b_flag), .link(link), .illegal(illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic exp_t ref_exec(word_t w, word_t a, word_t b, word_t cur_hi,
                                      word_t cur_lo);
        exp_t        e;
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [4:0]  rt;
        logic [4:0]  sa;
        word_t       simm;
        word_t       zimm;
        longint      sprod;
        opc  = w[31:26];
        rt   = w[20:16];
        sa   = w[10:6];
        fn   = w[5:0];
        simm = {{16{w[15]}}, w[15:0]};
        zimm = {16'h0000, w[15:0]};
        e    = '0;
        e.hi = cur_hi;
        e.lo = cur_lo;
        e.mem_addr = (opc >= `OP_ANDI && opc <= `OP_LUI) ? a + zimm : a + simm;
        case (opc)
            `OP_SPECIAL: case (fn)
                `FN_SLL:  e.result = b << sa;
                `FN_SRL:  e.result = b >> sa;
                `FN_SRA:  e.result = (b >> sa) | ~({32{1'b1}} >> sa) & {32{b[31]}};
                `FN_SLLV: e.result = b << a[4:0];
                `FN_SRLV: e.result = b >> a[4:0];
                `FN_SRAV: e.result = (b >> a[4:0]) | ~({32{1'b1}} >> a[4:0]) & {32{b[31]}};
                `FN_MFHI: e.result = cur_hi;
                `FN_MFLO: e.result = cur_lo;
                `FN_MTHI: e.hi = a;
                `FN_MTLO: e.lo = a;
                `FN_MULT: begin
                    sprod = longint'(int'(a)) * longint'(int'(b));
                    {e.hi, e.lo} = sprod;
                end
                `FN_MULTU: {e.hi, e.lo} = {32'h0, a} * {32'h0, b};
                `FN_DIV, `FN_DIVU: begin
                    if (b == 0) begin
                        e.hi = a; // divide by zero rule
                        e.lo = 32'hFFFF_FFFF;
                    end else if (fn == `FN_DIV) begin
                        e.lo = int'(a) / int'(b);
                        e.hi = int'(a) % int'(b);
                    end else begin
                        e.lo = a / b;
                        e.hi = a % b;
                    end
                end
                `FN_ADD, `FN_ADDU: e.result = a + b;
                `FN_SUB, `FN_SUBU: e.result = a - b;
                `FN_AND:  e.result = a & b;
                `FN_OR:   e.result = a | b;
                `FN_XOR:  e.result = a ^ b;
                `FN_NOR:  e.result = ~(a | b);
                `FN_SLT:  e.result = (int'(a) < int'(b));
                `FN_SLTU: e.result = (a < b);
                default:  e.illegal = 1'b1;
            endcase
            `OP_REGIMM: begin
                e.b_flag  = (rt[0]) ? !a[31] : a[31]; // odd rt means >= 0
                e.link    = (rt == `RT_BLTZAL || rt == `RT_BGEZAL);
                e.illegal = !(rt == `RT_BLTZ || rt == `RT_BGEZ || e.link);
                if (e.illegal) e.b_flag = 1'b0;
            end
            `OP_BEQ:   e.b_flag = (a == b);
            `OP_BNE:   e.b_flag = (a != b);
            `OP_BLEZ:  e.b_flag = a[31] || (a == 0);
            `OP_BGTZ:  e.b_flag = !a[31] && (a != 0);
            `OP_ADDI, `OP_ADDIU: e.result = a + simm;
            `OP_SLTI:  e.result = (int'(a) < int'(simm));
            `OP_SLTIU: e.result = (a < simm);
            `OP_ANDI:  e.result = a & zimm;
            `OP_ORI:   e.result = a | zimm;
            `OP_XORI:  e.result = a ^ zimm;
            `OP_LUI:   e.result = {w[15:0], 16'h0000};
            `OP_LB, `OP_LH, `OP_LWL, `OP_LW, `OP_LBU, `OP_LHU, `OP_LWR,
            `OP_SB, `OP_SH, `OP_SWL, `OP_SW: ; // address only
            default:   e.illegal = 1'b1;
        endcase
        return e;
    endfunction

    function automatic word_t r_word(logic [5:0] fn, logic [4:0] sa);
        return {`OP_SPECIAL, 5'd4, 5'd5, 5'd6, sa, fn};
    endfunction

    function automatic word_t i_word(logic [5:0] opc, logic [4:0] rt, logic [15:0] imm);
        return {opc, 5'd4, rt, imm};
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // compare before the model takes the edge's HI/LO write
    always @(posedge clk) begin
        if (checking) begin
            e_now = ref_exec(instr, op1, op2, m_hi, m_lo);
            check_word("result", e_now.result, result);
            check_word("mem_addr", e_now.mem_addr, mem_addr);
            check_word("hi", m_hi, hi);
            check_word("lo", m_lo, lo);
            check_bit("b_flag", e_now.b_flag, b_flag);
            check_bit("link", e_now.link, link);
            check_bit("illegal", e_now.illegal, illegal);
            if (instr_valid) begin
                m_hi = e_now.hi;
                m_lo = e_now.lo;
            end
        end
    end

    task automatic drive(input word_t w, input word_t a, input word_t b, input logic v);
        @(negedge clk);
        instr       = w;
        op1         = a;
        op2         = b;
        instr_valid = v;
    endtask

    task automatic hilo_seq(input word_t w, input word_t a, input word_t b, input logic v);
        drive(w, a, b, v);
        drive(r_word(`FN_MFHI, 5'd0), 32'h0, 32'h0, 1'b1); // reads the new value
        drive(r_word(`FN_MFLO, 5'd0), 32'h0, 32'h0, 1'b1);
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        instr_valid = 1'b0;
        tests_run++;
        $display("test %0d %s: %s (%0d errors)", tests_run, name,
                 (errors == test_errs) ? "pass" : "fail", errors - test_errs);
        test_errs = errors;
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic [5:0] fn_list [16];
        logic [5:0] imm_list [8];
        logic [5:0] mem_list [11];
        logic [4:0] sh_list [4];
        word_t      a_list [4];
        word_t      br_list [8];
        word_t      rnd, w, b;
        exp_t       probe;
        int         i, j, tries;
        arst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        op1 = '0;
        op2 = '0;
        m_hi = '0;
        m_lo = '0;
        checking = 1'b0;
        errors = 0;
        checks = 0;
        test_errs = 0;
        tests_run = 0;
        fn_list = '{`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV,
            `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR,
            `FN_SLT, `FN_SLTU};
        imm_list = '{`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI,
            `OP_ORI, `OP_XORI, `OP_LUI};
        mem_list = '{`OP_LB, `OP_LH, `OP_LWL, `OP_LW, `OP_LBU, `OP_LHU,
            `OP_LWR, `OP_SB, `OP_SH, `OP_SWL, `OP_SW};
        sh_list = '{5'd1, 5'd8, 5'd16, 5'd31};
        a_list = '{32'h0, 32'd77, 32'hFFFF_FF85, 32'h1234_5678};
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        checking = 1'b1;

        drive(32'h0, 32'h0, 32'h0, 1'b0); // nop, hi/lo still clear
        drive(32'h0, 32'h0, 32'h0, 1'b1);
        finish_test("reset");

        for (i = 0; i < 16; i++) begin
            for (j = 0; j < N_RAND; j++) begin
                rnd = $random(seed);
                drive(r_word(fn_list[i], rnd[10:6]), $random(seed), $random(seed), 1'b1);
            end
        end
        for (j = 0; j < 4; j++) begin
            rnd = $random(seed) | 32'h8000_0000; // negative rt
            drive(r_word(`FN_SRA, sh_list[j]), $random(seed), rnd, 1'b1);
            drive(r_word(`FN_SRAV, 5'd0), 32'h0000_0100 | sh_list[j], rnd, 1'b1);
        end
        finish_test("r-type alu and shifts");

        for (i = 0; i < 8; i++) begin
            for (j = 0; j < N_RAND; j++) begin
                rnd = $random(seed);
                drive(i_word(imm_list[i], 5'd2, rnd[15:0]), $random(seed), 32'h0, 1'b1);
            end
        end
        drive(i_word(`OP_SLTIU, 5'd2, 16'hFFF0), 32'h0000_0005, 32'h0, 1'b1);
        drive(i_word(`OP_SLTIU, 5'd2, 16'hFFF0), 32'h0001_0000, 32'h0, 1'b1); // above 16 bits
        for (i = 0; i < 11; i++) begin
            for (j = 0; j < 4; j++) begin
                rnd = $random(seed);
                drive(i_word(mem_list[i], 5'd2, rnd[15:0]), $random(seed), $random(seed), 1'b1);
            end
        end
        finish_test("immediates and addresses");

        br_list = '{i_word(`OP_BEQ, 5'd5, 16'h10), i_word(`OP_BNE, 5'd5, 16'h10),
            i_word(`OP_BLEZ, 5'd0, 16'h10), i_word(`OP_BGTZ, 5'd0, 16'h10),
            i_word(`OP_REGIMM, `RT_BLTZ, 16'h10), i_word(`OP_REGIMM, `RT_BGEZ, 16'h10),
            i_word(`OP_REGIMM, `RT_BLTZAL, 16'h10), i_word(`OP_REGIMM, `RT_BGEZAL, 16'h10)};
        for (i = 0; i < 8; i++) begin
            for (j = 0; j < 4; j++) begin
                rnd = $random(seed);
                b = (j == 0 || j == 3) ? a_list[j] : rnd; // zero and equal pairs
                drive(br_list[i], a_list[j], b, 1'b1);
            end
        end
        finish_test("branches");

        hilo_seq(r_word(`FN_MULT, 5'd0), 32'hFFFF_FFF9, 32'd12345, 1'b1);
        hilo_seq(r_word(`FN_MULTU, 5'd0), 32'hFFFF_FFFF, 32'd2, 1'b1);
        hilo_seq(r_word(`FN_DIV, 5'd0), 32'hFFFF_FF9C, 32'd7, 1'b1);
        hilo_seq(r_word(`FN_DIVU, 5'd0), 32'd100, 32'd7, 1'b1);
        hilo_seq(r_word(`FN_DIV, 5'd0), 32'd55, 32'h0, 1'b1);
        hilo_seq(r_word(`FN_DIVU, 5'd0), 32'hDEAD_BEEF, 32'h0, 1'b1);
        hilo_seq(r_word(`FN_MTHI, 5'd0), 32'hA5A5_0F0F, 32'h0, 1'b1);
        hilo_seq(r_word(`FN_MTLO, 5'd0), 32'h5A5A_F0F0, 32'h0, 1'b1);
        hilo_seq(r_word(`FN_MULT, 5'd0), 32'd3, 32'd4, 1'b0); // not valid, no write
        finish_test("hi/lo sequences");

        for (i = 0; i < N_ILL; i++) begin
            probe = '0;
            tries = 0;
            while (!probe.illegal && tries < 200) begin
                w = $random(seed);
                if (i % 3 == 0) w[31:26] = `OP_SPECIAL;
                if (i % 3 == 1) w[31:26] = `OP_REGIMM;
                probe = ref_exec(w, 32'h0, 32'h0, 32'h0, 32'h0);
                tries++;
            end
            drive(w, $random(seed), $random(seed), 1'b1);
        end
        finish_test("illegal encodings");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verilog/alu_ctrl_if.sv */
`timescale 1ns/1ps

interface alu_ctrl_if
    import alu_pkg::*;
(
    input logic clk // only samples assertions
);
    alu_op_e    alu_op;
    logic       use_imm;   // operand b from imm
    word_t      imm;       // already extended
    logic       shamt_sel; // shift amount from op1
    logic [4:0] shamt;
    br_cond_e   br_cond;
    logic       link;
    logic       mem_op;    // load or store
    logic       wr_hi;
    logic       wr_lo;
    res_sel_e   res_sel;
    logic       illegal;

    modport dec (input clk, output alu_op, use_imm, imm, shamt_sel, shamt,
                 br_cond, link, mem_op, wr_hi, wr_lo, res_sel, illegal);

    modport exe (input clk, alu_op, use_imm, imm, shamt_sel, shamt, br_cond, mem_op);

    modport res (input wr_hi, wr_lo, res_sel);

endinterface

/* verilog/alu_execute.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_execute
    import alu_pkg::*;
(
    input  word_t   op1,
    input  word_t   op2,
    alu_ctrl_if.exe ctrl,
    output word_t   alu_out,
    output logic    b_flag,
    output word_t   mem_addr,
    output word_t   hi_next,
    output word_t   lo_next
);
    word_t                           b_opnd;
    logic [4:0]                      sh_amt;
    logic signed [2*`ALU_XLEN-1:0]   prod_s;
    logic        [2*`ALU_XLEN-1:0]   prod_u;

    assign b_opnd = ctrl.use_imm ? ctrl.imm : op2;
    assign sh_amt = ctrl.shamt_sel ? op1[4:0] : ctrl.shamt; // variable shifts use rs[4:0]

    assign prod_s = $signed(op1) * $signed(op2); // widened to 64 before multiply
    assign prod_u = op1 * op2;

    assign mem_addr = op1 + ctrl.imm;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  alu_out = op1 + b_opnd;
            ALU_SUB:  alu_out = op1 - b_opnd;
            ALU_AND:  alu_out = op1 & b_opnd;
            ALU_OR:   alu_out = op1 | b_opnd;
            ALU_XOR:  alu_out = op1 ^ b_opnd;
            ALU_NOR:  alu_out = ~(op1 | b_opnd);
            ALU_SLT:  alu_out = word_t'($signed(op1) < $signed(b_opnd));
            ALU_SLTU: alu_out = word_t'(op1 < b_opnd);
            ALU_SLL:  alu_out = op2 << sh_amt; // shifts act on rt
            ALU_SRL:  alu_out = op2 >> sh_amt;
            ALU_SRA:  alu_out = $signed(op2) >>> sh_amt; // sign fill
            ALU_LUI:  alu_out = {b_opnd[15:0], 16'h0000};
            default:  alu_out = '0;
        endcase
    end

    always_comb begin
        hi_next = '0;
        lo_next = '0;
        case (ctrl.alu_op)
            ALU_MULT:  {hi_next, lo_next} = prod_s;
            ALU_MULTU: {hi_next, lo_next} = prod_u;
            ALU_DIV: begin
                if (op2 == '0) begin
                    hi_next = op1; // defined divide-by-zero result
                    lo_next = '1;
                end else begin
                    hi_next = $signed(op1) % $signed(op2);
                    lo_next = $signed(op1) / $signed(op2);
                end
            end
            ALU_DIVU: begin
                if (op2 == '0) begin
                    hi_next = op1;
                    lo_next = '1;
                end else begin
                    hi_next = op1 % op2;
                    lo_next = op1 / op2;
                end
            end
            ALU_PASS_A: begin
                hi_next = op1; // MTHI / MTLO, enable picks the target
                lo_next = op1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   b_flag = (op1 == op2);
            BR_NE:   b_flag = (op1 != op2);
            BR_LEZ:  b_flag = ($signed(op1) <= 0);
            BR_GTZ:  b_flag = ($signed(op1) > 0);
            BR_LTZ:  b_flag = op1[`ALU_XLEN-1];
            BR_GEZ:  b_flag = !op1[`ALU_XLEN-1];
            default: b_flag = 1'b0;
        endcase
    end

    // taken branch only from a decoded branch, never from a load/store
    a_bflag_src: assert property (@(posedge ctrl.clk)
        b_flag |-> (ctrl.br_cond != BR_NONE) && !ctrl.mem_op);

endmodule

/* verilog/alu_pkg.sv */
`include "alu_macros.svh"

package alu_pkg;

    typedef logic [`ALU_XLEN-1:0] word_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // same word, R view for funct/shamt, I view for the immediate
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_word_t;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
        ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU, ALU_PASS_A, ALU_NONE
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
    } br_cond_e;

    typedef enum logic [1:0] {
        RES_ALU, RES_HI, RES_LO, RES_ZERO
    } res_sel_e;

endpackage

/* verilog/hilo_result.sv */
`timescale 1ns/1ps

module hilo_result
    import alu_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    instr_valid,
    alu_ctrl_if.res ctrl,
    input  word_t   alu_out,
    input  word_t   hi_next,
    input  word_t   lo_next,
    output word_t   hi,
    output word_t   lo,
    output word_t   result
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= '0;
        end else if (instr_valid && ctrl.wr_hi) begin
            hi <= hi_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lo <= '0;
        end else if (instr_valid && ctrl.wr_lo) begin
            lo <= lo_next;
        end
    end

    // MFHI/MFLO see the registered value
    always_comb begin
        case (ctrl.res_sel)
            RES_ALU: result = alu_out;
            RES_HI:  result = hi;
            RES_LO:  result = lo;
            default: result = '0;
        endcase
    end

    a_hi_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !(instr_valid && ctrl.wr_hi) |=> $stable(hi));

    a_lo_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !(instr_valid && ctrl.wr_lo) |=> $stable(lo));

endmodule

/* verilog/instr_decode.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module instr_decode
    import alu_pkg::*;
(
    input instr_word_t instr,
    alu_ctrl_if.dec    ctrl
);
    word_t simm;
    word_t uimm;

    assign simm = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign uimm = {16'h0000, instr.i.imm};

    always_comb begin
        ctrl.alu_op    = ALU_NONE;
        ctrl.use_imm   = 1'b0;
        ctrl.imm       = simm;
        ctrl.shamt_sel = 1'b0;
        ctrl.shamt     = instr.r.shamt;
        ctrl.br_cond   = BR_NONE;
        ctrl.link      = 1'b0;
        ctrl.mem_op    = 1'b0;
        ctrl.wr_hi     = 1'b0;
        ctrl.wr_lo     = 1'b0;
        ctrl.res_sel   = RES_ALU;
        ctrl.illegal   = 1'b0;
        case (instr.r.opcode)
            `OP_SPECIAL: begin
                case (instr.r.funct)
                    `FN_SLL:  ctrl.alu_op = ALU_SLL;
                    `FN_SRL:  ctrl.alu_op = ALU_SRL;
                    `FN_SRA:  ctrl.alu_op = ALU_SRA;
                    `FN_SLLV: begin
                        ctrl.alu_op    = ALU_SLL;
                        ctrl.shamt_sel = 1'b1;
                    end
                    `FN_SRLV: begin
                        ctrl.alu_op    = ALU_SRL;
                        ctrl.shamt_sel = 1'b1;
                    end
                    `FN_SRAV: begin
                        ctrl.alu_op    = ALU_SRA;
                        ctrl.shamt_sel = 1'b1;
                    end
                    `FN_MFHI: ctrl.res_sel = RES_HI;
                    `FN_MFLO: ctrl.res_sel = RES_LO;
                    `FN_MTHI: begin
                        ctrl.alu_op  = ALU_PASS_A;
                        ctrl.wr_hi   = 1'b1;
                        ctrl.res_sel = RES_ZERO;
                    end
                    `FN_MTLO: begin
                        ctrl.alu_op  = ALU_PASS_A;
                        ctrl.wr_lo   = 1'b1;
                        ctrl.res_sel = RES_ZERO;
                    end
                    `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU: begin
                        ctrl.wr_hi   = 1'b1;
                        ctrl.wr_lo   = 1'b1;
                        ctrl.res_sel = RES_ZERO;
                        case (instr.r.funct)
                            `FN_MULT:  ctrl.alu_op = ALU_MULT;
                            `FN_MULTU: ctrl.alu_op = ALU_MULTU;
                            `FN_DIV:   ctrl.alu_op = ALU_DIV;
                            default:   ctrl.alu_op = ALU_DIVU;
                        endcase
                    end
                    `FN_ADD, `FN_ADDU: ctrl.alu_op = ALU_ADD; // no overflow trap
                    `FN_SUB, `FN_SUBU: ctrl.alu_op = ALU_SUB;
                    `FN_AND:  ctrl.alu_op = ALU_AND;
                    `FN_OR:   ctrl.alu_op = ALU_OR;
                    `FN_XOR:  ctrl.alu_op = ALU_XOR;
                    `FN_NOR:  ctrl.alu_op = ALU_NOR;
                    `FN_SLT:  ctrl.alu_op = ALU_SLT;
                    `FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    default: begin
                        ctrl.illegal = 1'b1;
                        ctrl.res_sel = RES_ZERO;
                    end
                endcase
            end
            `OP_REGIMM: begin
                ctrl.res_sel = RES_ZERO;
                case (instr.i.rt)
                    `RT_BLTZ: ctrl.br_cond = BR_LTZ;
                    `RT_BGEZ: ctrl.br_cond = BR_GEZ;
                    `RT_BLTZAL: begin
                        ctrl.br_cond = BR_LTZ;
                        ctrl.link    = 1'b1; // taken or not
                    end
                    `RT_BGEZAL: begin
                        ctrl.br_cond = BR_GEZ;
                        ctrl.link    = 1'b1;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: begin
                ctrl.res_sel = RES_ZERO;
                case (instr.i.opcode)
                    `OP_BEQ:  ctrl.br_cond = BR_EQ;
                    `OP_BNE:  ctrl.br_cond = BR_NE;
                    `OP_BLEZ: ctrl.br_cond = BR_LEZ;
                    default:  ctrl.br_cond = BR_GTZ;
                endcase
            end
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU: begin
                ctrl.use_imm = 1'b1;
                case (instr.i.opcode)
                    `OP_SLTI:  ctrl.alu_op = ALU_SLT;
                    `OP_SLTIU: ctrl.alu_op = ALU_SLTU; // unsigned vs sign-extended imm
                    default:   ctrl.alu_op = ALU_ADD;
                endcase
            end
            `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                ctrl.use_imm = 1'b1;
                ctrl.imm     = uimm; // logic forms zero-extend
                case (instr.i.opcode)
                    `OP_ANDI: ctrl.alu_op = ALU_AND;
                    `OP_ORI:  ctrl.alu_op = ALU_OR;
                    `OP_XORI: ctrl.alu_op = ALU_XOR;
                    default:  ctrl.alu_op = ALU_LUI;
                endcase
            end
            `OP_LB, `OP_LH, `OP_LWL, `OP_LW, `OP_LBU, `OP_LHU, `OP_LWR,
            `OP_SB, `OP_SH, `OP_SWL, `OP_SW: begin
                ctrl.mem_op  = 1'b1; // address only, data handled elsewhere
                ctrl.res_sel = RES_ZERO;
            end
            default: begin
                ctrl.illegal = 1'b1;
                ctrl.res_sel = RES_ZERO;
            end
        endcase
    end

    // an illegal word must never reach the HI/LO write path
    a_illegal_no_wr: assert property (@(posedge ctrl.clk)
        ctrl.illegal |-> !(ctrl.wr_hi || ctrl.wr_lo));

endmodule

/* verilog/mips_alu_top.sv */
`timescale 1ns/1ps

module mips_alu_top
    import alu_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  instr_valid, // qualifies HI/LO writes only
    input  word_t instr,
    input  word_t op1,         // rs
    input  word_t op2,         // rt
    output word_t result,
    output word_t hi,
    output word_t lo,
    output word_t mem_addr,
    output logic  b_flag,
    output logic  link,
    output logic  illegal
);
    word_t alu_out;
    word_t hi_next;
    word_t lo_next;

    alu_ctrl_if u_ctrl_if (.clk(clk));

    instr_decode u_decode (
        .instr (instr_word_t'(instr)),
        .ctrl  (u_ctrl_if.dec)
    );

    alu_execute u_execute (
        .op1      (op1),
        .op2      (op2),
        .ctrl     (u_ctrl_if.exe),
        .alu_out  (alu_out),
        .b_flag   (b_flag),
        .mem_addr (mem_addr),
        .hi_next  (hi_next),
        .lo_next  (lo_next)
    );

    hilo_result u_result (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .ctrl        (u_ctrl_if.res),
        .alu_out     (alu_out),
        .hi_next     (hi_next),
        .lo_next     (lo_next),
        .hi          (hi),
        .lo          (lo),
        .result      (result)
    );

    assign link    = u_ctrl_if.link;
    assign illegal = u_ctrl_if.illegal;

endmodule
